//--- test/ejtag_trace.txt
// Columns: operation, operand, expected (hex). 01 scan write, 02 scan read (operand is mask),
// 03 DCR write, 04 DCR compare (mask), 05 DMA start, 06 dma_done, 07 probe access, 08 jtag_dint,
// 09 dint wait, 0A debug entry, 0B status, 0C ej_dis, 0D strobe wait, 0E dcr_tm and dcr_mint.
0B 00000008 00000000
01 FD00C471 00000000
02 FFF7FFFF 8120C031
0C 00000001 00000000
01 00000800 00000000
05 00000000 00000000
02 FFF7FFFF 00220100
0C 00000000 00000000
01 00000A90 00000000
05 00000001 00000005
02 FFF7FFFF 00200A90
06 00000000 00000000
02 FFF7FFFF 00200290
03 FFFFFF91 00000000
04 FFFFFFFF 20000011
0E 00000000 00000003
0B 0000000E 00000000
04 FFFFFFFF E0000011
0B 00000008 00000000
08 00000001 00000001
08 00000000 00000000
01 00001000 00000000
09 00000000 00000001
02 00001000 00001000
0A 00000000 00000000
09 00000000 00000000
02 00001000 00000000
07 00000000 00000000
02 00040000 00040000
01 00000000 00000000
0D 00000000 00000000
02 00040000 00000000
02 FFFFFFFF 00200000
00 00000000 00000000

//--- vlog.f
common/ejtag_pkg.sv
ejtag_control/ejtag_setclr.sv
ejtag_control/ejtag_control.sv
source/ejtag_ctl_scan.sv
source/ejtag_top.sv
test/ejtag_sva.sv
test/ejtag_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module ejtag_tb -o ejtag_sim
./obj_dir/ejtag_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Done: errors found" sim.log; then
  exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
  echo "Simulation ended without a result line."
  exit 1
fi
exit 0

//--- test/ejtag_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ejtag_tb;

  import ejtag_pkg::*;

  localparam int MAX_STEPS = 50;
  localparam int JTAG_PERIOD = 30;

  logic                CORE_CLOCK;
  logic                RESET_D1_JR_N;
  logic                jtag_clock;
  logic                sel_ctl;
  logic                capture_dr;
  logic                shift_dr;
  logic                update_dr;
  logic                tdi;
  logic                ej_dis;
  logic [31:0]         mem_wdata;
  logic                mem_write;
  logic                sel_dcr;
  logic                sel_probe;
  logic                mem_toggle;
  logic                dma_done;
  logic                jtag_dint;
  core_status_t        status;
  logic                tdo;
  dcr_t                debug_ctl;
  dma_req_t            dma_req;
  logic                probe_strobe;
  logic                dint;
  logic                probe_en;
  logic                probe_reset;
  logic                dcr_tm;
  logic                dcr_mint;

  logic [31:0] trace_mem [0:3*MAX_STEPS-1];
  int          step_count;
  int          error_count;
  int          check_count;
  logic        steps_ready;
  logic [31:0] ecr_written;

  ejtag_top #(.CTL_WIDTH(32)) dut0 (.*);

  initial begin
    CORE_CLOCK = 1'b0;
    forever #5 CORE_CLOCK = ~CORE_CLOCK;
  end

  initial begin
    jtag_clock = 1'b0;
    forever #(JTAG_PERIOD / 2) jtag_clock = ~jtag_clock;
  end

  initial begin
    wait (steps_ready);
    #(step_count * 200 * JTAG_PERIOD + 10 * 10);
    $display("Watchdog expired before the trace finished.");
    $display("Steps: %0d, checks: %0d, errors: %0d", step_count, check_count, error_count);
    $display("Done: errors found");
    $finish;
  end

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    error_count++;
    $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic complain(input string text);
    error_count++;
    $display("ERROR at %0t: %s", $time, text);
  endtask

  // Capture, shift 32 bits LSB first, and optionally update.
  task automatic scan_dr(input logic [31:0] din, input bit do_update, output logic [31:0] dout);
    int i;
    @(negedge jtag_clock);
    sel_ctl    = 1'b1;
    capture_dr = 1'b1;
    @(negedge jtag_clock);
    capture_dr = 1'b0;
    shift_dr   = 1'b1;
    for (i = 0; i < 32; i++) begin
      dout[i] = tdo;
      tdi     = din[i];
      @(negedge jtag_clock);
    end
    shift_dr  = 1'b0;
    update_dr = do_update;
    @(negedge jtag_clock);
    update_dr = 1'b0;
    sel_ctl   = 1'b0;
  endtask

  task automatic expect_probe_strobe();
    int  n;
    logic seen;
    seen = 1'b0;
    for (n = 0; n < 8 && !seen; n++) begin
      @(negedge CORE_CLOCK);
      if (probe_strobe) seen = 1'b1;
    end
    check_count++;
    if (!seen) begin
      complain("probe_strobe did not pulse within 8 core cycles");
    end else begin
      @(negedge CORE_CLOCK);
      if (probe_strobe !== 1'b0) mismatch("probe_strobe", probe_strobe, 0);
    end
  endtask

  task automatic run_step(input logic [7:0] op, input logic [31:0] arg, input logic [31:0] exp);
    logic [31:0] rd;
    int          n;
    logic        seen;
    case (op)
      8'h01: begin
        ecr_written = ej_dis ? ECR_DISABLED : arg; // ECR content after the update.
        scan_dr(arg, 1'b1, rd);
      end
      8'h02: begin // Retry while live flags settle.
        n = 0;
        do begin
          scan_dr(32'h0, 1'b0, rd);
          n++;
        end while ((rd & arg) !== exp && n < 8);
        check_count++;
        if ((rd & arg) !== exp) mismatch("ecr_read", rd & arg, exp);
        check_count++;
        if (probe_en !== (ecr_written[15] & ~ecr_written[14])) begin
          mismatch("probe_en", probe_en, ecr_written[15] & ~ecr_written[14]);
        end
        check_count++;
        if (probe_reset !== ecr_written[16]) begin
          mismatch("probe_reset", probe_reset, ecr_written[16]);
        end
      end
      8'h03: begin
        @(negedge CORE_CLOCK);
        mem_wdata = arg;
        mem_write = 1'b1;
        sel_dcr   = 1'b1;
        @(negedge CORE_CLOCK);
        mem_write = 1'b0;
        sel_dcr   = 1'b0;
      end
      8'h04: begin
        check_count++;
        if ((debug_ctl & arg) !== exp) mismatch("debug_ctl", debug_ctl & arg, exp);
      end
      8'h05: begin
        seen = 1'b0;
        for (n = 0; n < 8 && !seen; n++) begin
          @(negedge CORE_CLOCK);
          if (dma_req.start) seen = 1'b1;
        end
        check_count++;
        if (arg[0] && !seen) begin
          complain("dma_req.start did not pulse within 8 core cycles");
        end else if (!arg[0] && seen) begin
          mismatch("dma_req.start", 1, 0);
        end else if (seen) begin
          if ({dma_req.read, dma_req.size} !== exp[2:0]) begin
            mismatch("dma_req.read_size", {dma_req.read, dma_req.size}, exp);
          end
          if (dma_req.inc !== ecr_written[4]) begin
            mismatch("dma_req.inc", dma_req.inc, ecr_written[4]);
          end
          @(negedge CORE_CLOCK);
          if (dma_req.start !== 1'b0) mismatch("dma_req.start", dma_req.start, 0);
        end
      end
      8'h06: begin
        @(negedge CORE_CLOCK);
        dma_done = 1'b1;
        @(negedge CORE_CLOCK);
        dma_done = 1'b0;
      end
      8'h07: begin
        @(negedge CORE_CLOCK);
        sel_probe  = 1'b1;
        mem_toggle = ~mem_toggle;
        expect_probe_strobe();
        sel_probe  = 1'b0;
      end
      8'h08: begin
        @(negedge CORE_CLOCK);
        jtag_dint = arg[0];
        @(negedge CORE_CLOCK);
        check_count++;
        if (dint !== exp[0]) mismatch("dint", dint, exp);
      end
      8'h09: begin
        for (n = 0; n < 8 && dint !== exp[0]; n++) @(negedge CORE_CLOCK);
        check_count++;
        if (dint !== exp[0]) complain("dint did not reach its expected level within 8 cycles");
      end
      8'h0A: begin
        @(negedge CORE_CLOCK);
        status.debug_entry = 1'b1;
        @(negedge CORE_CLOCK);
        status.debug_entry = 1'b0;
      end
      8'h0B: begin
        @(negedge CORE_CLOCK);
        status = core_status_t'(arg[3:0]);
        @(negedge CORE_CLOCK); // His and dzs are registered.
      end
      8'h0C: begin
        @(negedge jtag_clock);
        ej_dis = arg[0];
      end
      8'h0D: expect_probe_strobe();
      8'h0E: begin
        for (n = 0; n < 3 && {dcr_tm, dcr_mint} !== exp[1:0]; n++) @(negedge CORE_CLOCK);
        check_count++;
        if ({dcr_tm, dcr_mint} !== exp[1:0]) mismatch("dcr_tm_mint", {dcr_tm, dcr_mint}, exp);
      end
      default: complain("unknown operation code in trace");
    endcase
  endtask

  initial begin
    int s;
    RESET_D1_JR_N = 1'b0;
    sel_ctl     = 1'b0;
    capture_dr  = 1'b0;
    shift_dr    = 1'b0;
    update_dr   = 1'b0;
    tdi         = 1'b0;
    ej_dis      = 1'b0;
    mem_wdata   = '0;
    mem_write   = 1'b0;
    sel_dcr     = 1'b0;
    sel_probe   = 1'b0;
    mem_toggle  = 1'b0;
    dma_done    = 1'b0;
    jtag_dint   = 1'b0;
    status      = 4'b1000;
    error_count = 0;
    check_count = 0;
    steps_ready = 1'b0;
    ecr_written = '0;
    for (s = 0; s < 3 * MAX_STEPS; s++) trace_mem[s] = '0;
    $readmemh("test/ejtag_trace.txt", trace_mem);
    step_count = 0;
    while (step_count < MAX_STEPS && trace_mem[3*step_count][7:0] != 8'h00) step_count++;
    steps_ready = 1'b1;
    repeat (10) @(posedge CORE_CLOCK);
    @(negedge CORE_CLOCK);
    RESET_D1_JR_N = 1'b1;
    repeat (3) @(negedge jtag_clock); // Let the reset synchronizers release.
    for (s = 0; s < step_count; s++) begin
      run_step(trace_mem[3*s][7:0], trace_mem[3*s+1], trace_mem[3*s+2]);
    end
    $display("Steps: %0d, checks: %0d, errors: %0d", step_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/ejtag_sva.sv
`timescale 1ns/10ps
`default_nettype none

module ejtag_sva (
  input wire                      CORE_CLOCK,
  input wire                      RESET_D1_JR_N,
  input wire                      core_rst_n,
  input wire ejtag_pkg::dma_req_t dma_req,
  input wire                      probe_strobe,
  input wire                      dint,
  input wire                      jtag_dint
);

  dma_start_single: assert property (@(posedge CORE_CLOCK) disable iff (!core_rst_n)
    dma_req.start |=> !dma_req.start)
    else $error("dma_req.start lasted more than one cycle");

  strobe_low_in_reset: assert property (@(posedge CORE_CLOCK)
    !RESET_D1_JR_N |-> !probe_strobe)
    else $error("probe_strobe high during reset");

  dint_follows: assert property (@(posedge CORE_CLOCK) disable iff (!core_rst_n)
    jtag_dint |=> dint)
    else $error("dint did not follow jtag_dint");

endmodule

bind ejtag_control ejtag_sva sva0 (
  .CORE_CLOCK    (CORE_CLOCK),
  .RESET_D1_JR_N (RESET_D1_JR_N),
  .core_rst_n    (core_rst_n),
  .dma_req       (dma_req),
  .probe_strobe  (probe_strobe),
  .dint          (dint),
  .jtag_dint     (jtag_dint)
);

`default_nettype wire

//--- source/ejtag_top.sv
`timescale 1ns/10ps
`default_nettype none

module ejtag_top #(
  parameter int CTL_WIDTH = ejtag_pkg::ECR_BITS
) (
  input  wire                          CORE_CLOCK,
  input  wire                          RESET_D1_JR_N,
  input  wire                          jtag_clock,
  input  wire                          sel_ctl,
  input  wire                          capture_dr,
  input  wire                          shift_dr,
  input  wire                          update_dr,
  input  wire                          tdi,
  input  wire                          ej_dis,
  input  wire [31:0]                   mem_wdata,
  input  wire                          mem_write,
  input  wire                          sel_dcr,
  input  wire                          sel_probe,
  input  wire                          mem_toggle,
  input  wire                          dma_done,
  input  wire                          jtag_dint,
  input  wire ejtag_pkg::core_status_t status,
  output logic                         tdo,
  output ejtag_pkg::dcr_t              debug_ctl,
  output ejtag_pkg::dma_req_t          dma_req,
  output logic                         probe_strobe,
  output logic                         dint,
  output logic                         probe_en,
  output logic                         probe_reset,
  output logic                         dcr_tm,
  output logic                         dcr_mint
);

  import ejtag_pkg::*;

  ecr_t ctl_view;
  ecr_t ctl_word;
  logic ctl_update;

  ejtag_ctl_scan #(
    .CTL_WIDTH (CTL_WIDTH)
  ) scan0 (
    .jtag_clock    (jtag_clock),
    .RESET_D1_JR_N (RESET_D1_JR_N),
    .sel_ctl       (sel_ctl),
    .capture_dr    (capture_dr),
    .shift_dr      (shift_dr),
    .update_dr     (update_dr),
    .tdi           (tdi),
    .ctl_view      (ctl_view),
    .tdo           (tdo),
    .ctl_word      (ctl_word),
    .ctl_update    (ctl_update)
  );

  ejtag_control ctl0 (
    .CORE_CLOCK    (CORE_CLOCK),
    .jtag_clock    (jtag_clock),
    .RESET_D1_JR_N (RESET_D1_JR_N),
    .ej_dis        (ej_dis),
    .ctl_word      (ctl_word),
    .ctl_update    (ctl_update),
    .mem_wdata     (mem_wdata),
    .mem_write     (mem_write),
    .sel_dcr       (sel_dcr),
    .sel_probe     (sel_probe),
    .mem_toggle    (mem_toggle),
    .dma_done      (dma_done),
    .jtag_dint     (jtag_dint),
    .status        (status),
    .ctl_view      (ctl_view),
    .debug_ctl     (debug_ctl),
    .dma_req       (dma_req),
    .probe_strobe  (probe_strobe),
    .dint          (dint),
    .probe_en      (probe_en),
    .probe_reset   (probe_reset),
    .dcr_tm        (dcr_tm),
    .dcr_mint      (dcr_mint)
  );

endmodule

`default_nettype wire

//--- source/ejtag_ctl_scan.sv
`timescale 1ns/10ps
`default_nettype none

module ejtag_ctl_scan #(
  parameter int CTL_WIDTH = ejtag_pkg::ECR_BITS
) (
  input  wire                  jtag_clock,
  input  wire                  RESET_D1_JR_N,
  input  wire                  sel_ctl,
  input  wire                  capture_dr,
  input  wire                  shift_dr,
  input  wire                  update_dr,
  input  wire                  tdi,
  input  wire ejtag_pkg::ecr_t ctl_view,
  output logic                 tdo,
  output ejtag_pkg::ecr_t      ctl_word,
  output logic                 ctl_update
);

  import ejtag_pkg::*;

  localparam int COMMON = (CTL_WIDTH < ECR_BITS) ? CTL_WIDTH : ECR_BITS;

  logic [CTL_WIDTH-1:0] shift_q;
  logic [CTL_WIDTH-1:0] capture_val;
  logic [ECR_BITS-1:0]  word_val;
  logic                 update_q;

  always_comb begin
    capture_val = '0;
    word_val    = '0;
    for (int i = 0; i < COMMON; i++) begin
      capture_val[i] = ctl_view[i]; // Extra scan bits read as zero.
      word_val[i]    = shift_q[i];
    end
  end

  always_ff @(posedge jtag_clock) begin
    if (sel_ctl && capture_dr) begin
      shift_q <= capture_val;
    end else if (sel_ctl && shift_dr) begin
      shift_q <= {tdi, shift_q[CTL_WIDTH-1:1]};
    end
  end

  always_ff @(posedge jtag_clock or negedge RESET_D1_JR_N) begin
    if (!RESET_D1_JR_N) begin
      update_q <= 1'b0;
    end else begin
      update_q <= update_dr;
    end
  end

  assign tdo        = shift_q[0];
  assign ctl_word   = word_val;
  assign ctl_update = sel_ctl & update_dr & ~update_q; // One cycle per update.

endmodule

`default_nettype wire

//--- ejtag_control/ejtag_control.sv
`timescale 1ns/10ps
`default_nettype none

module ejtag_control (
  input  wire                     CORE_CLOCK,
  input  wire                     jtag_clock,
  input  wire                     RESET_D1_JR_N,
  input  wire                     ej_dis,
  input  wire ejtag_pkg::ecr_t    ctl_word,
  input  wire                     ctl_update,
  input  wire [31:0]              mem_wdata,
  input  wire                     mem_write,
  input  wire                     sel_dcr,
  input  wire                     sel_probe,
  input  wire                     mem_toggle,
  input  wire                     dma_done,
  input  wire                     jtag_dint,
  input  wire ejtag_pkg::core_status_t status,
  output ejtag_pkg::ecr_t         ctl_view,
  output ejtag_pkg::dcr_t         debug_ctl,
  output ejtag_pkg::dma_req_t     dma_req,
  output logic                    probe_strobe,
  output logic                    dint,
  output logic                    probe_en,
  output logic                    probe_reset,
  output logic                    dcr_tm,
  output logic                    dcr_mint
);

  import ejtag_pkg::*;

  logic [1:0] core_rst_q;
  logic       core_rst_n;
  ecr_t       ecr_q;
  dcr_t       dcr_q;
  dcr_t       dcr_d;
  dcr_t       dcr_wdata;
  logic       ecr_wr;
  logic       dcr_wr;
  logic       dma_start;
  logic       tif_start;
  logic       tif_done;
  logic       tof_start;
  logic       tof_done;
  logic       jtagbrk_start;
  logic       pracc_done;
  logic       probe_access;
  logic       dma_setq;
  logic       dma_clrq;
  logic       tif_setq;
  logic       tif_clrq;
  logic       tof_setq;
  logic       tof_clrq;
  logic       jtagbrk_setq;
  logic       jtagbrk_clrq;
  logic       pracc_setq;
  logic       pracc_clrq;
  logic       dma_clrq_q;
  logic       dma_go;
  logic       read_q;
  dma_size_e  size_q;
  logic       prnw_q;
  logic [1:0] mt_q;
  logic       access_q;
  logic       pracc_q;
  logic [3:0] sync_in;
  logic [3:0] sync_q1;
  logic [3:0] sync_q2;

  always_ff @(posedge CORE_CLOCK or negedge RESET_D1_JR_N) begin
    if (!RESET_D1_JR_N) begin
      core_rst_q <= 2'b00;
    end else begin
      core_rst_q <= {core_rst_q[0], 1'b1};
    end
  end

  assign core_rst_n = core_rst_q[1];

  assign ecr_wr        = ctl_update & ~ej_dis;
  assign dma_start     = ecr_wr & ctl_word.dstrt;
  assign tif_start     = ecr_wr & ctl_word.tif;
  assign jtagbrk_start = ecr_wr & ctl_word.jtagbrk;
  assign tof_done      = ecr_wr & ~ctl_word.tof;
  assign pracc_done    = ecr_wr & ~ctl_word.pracc; // Probe hands the access back.

  always_ff @(posedge jtag_clock or negedge RESET_D1_JR_N) begin
    if (!RESET_D1_JR_N) begin
      ecr_q <= '0;
    end else if (ctl_update) begin
      ecr_q <= ej_dis ? ECR_DISABLED : ctl_word;
    end
  end

  always_comb begin
    ctl_view          = ecr_q;
    ctl_view.res30_27 = '0;
    ctl_view.res26    = 1'b0;
    ctl_view.res23    = 1'b0;
    ctl_view.res13    = 1'b0;
    ctl_view.res6     = 1'b0;
    ctl_view.derr     = 1'b0;
    ctl_view.tof      = tof_clrq;
    ctl_view.tif      = tif_setq;
    ctl_view.dstrt    = dma_setq; // Stays set until the completion comes back.
    ctl_view.jtagbrk  = jtagbrk_setq;
    ctl_view.pracc    = pracc_clrq;
    ctl_view.prnw     = prnw_q;
    ctl_view.run      = status.run;
    ctl_view.doze     = status.doze;
  end

  assign dcr_wdata = dcr_t'(mem_wdata);
  assign dcr_wr    = mem_write & sel_dcr;
  assign tof_start = dcr_wr & dcr_wdata.tof;
  assign tif_done  = dcr_wr & ~dcr_wdata.tif;

  always_comb begin
    dcr_d = dcr_q;
    if (dcr_wr) begin
      dcr_d.tm   = dcr_wdata.tm;
      dcr_d.mrst = dcr_wdata.mrst;
      dcr_d.mp   = dcr_wdata.mp;
      dcr_d.mnmi = dcr_wdata.mnmi;
      dcr_d.mint = dcr_wdata.mint;
    end
    dcr_d.tof     = tof_setq;
    dcr_d.tif     = tif_clrq;
    dcr_d.res28_7 = '0;
    dcr_d.enm     = 1'b1;
    dcr_d.his     = status.halt;
    dcr_d.dzs     = status.doze;
  end

  assign debug_ctl = dcr_q;

  assign probe_access = sel_probe & (mt_q[0] ^ mt_q[1]);
  assign dma_go       = dma_clrq & ~dma_clrq_q;
  assign probe_strobe = access_q | (pracc_q & ~pracc_setq);
  assign sync_in      = {ecr_q.proben & ~ecr_q.setdev, ecr_q.prrst, dcr_q.tm, dcr_q.mint};

  assign {probe_en, probe_reset, dcr_tm, dcr_mint} = sync_q2;

  always_ff @(posedge CORE_CLOCK or negedge core_rst_n) begin
    if (!core_rst_n) begin
      dcr_q      <= '0;
      mt_q       <= 2'b00;
      access_q   <= 1'b0;
      pracc_q    <= 1'b0;
      dma_clrq_q <= 1'b0;
      dint       <= 1'b0;
      sync_q1    <= 4'b0000;
      sync_q2    <= 4'b0000;
    end else begin
      dcr_q      <= dcr_d;
      mt_q       <= {mt_q[0], mem_toggle};
      access_q   <= probe_access;
      pracc_q    <= pracc_setq;
      dma_clrq_q <= dma_clrq;
      dint       <= jtagbrk_clrq | jtag_dint;
      sync_q1    <= sync_in;
      sync_q2    <= sync_q1;
    end
  end

  always_ff @(posedge CORE_CLOCK) begin
    if (dma_go) begin
      read_q <= ecr_q.drwn;
      size_q <= dma_size_decode(ecr_q.dsz);
    end
    if (probe_access) begin
      prnw_q <= mem_write;
    end
  end

  always_comb begin
    dma_req.start = dma_go;
    dma_req.read  = dma_go ? ecr_q.drwn : read_q;
    dma_req.size  = dma_go ? dma_size_decode(ecr_q.dsz) : size_q;
    dma_req.inc   = ecr_q.dinc;
  end

  ejtag_setclr dma (
    .set_clock     (jtag_clock),
    .clr_clock     (CORE_CLOCK),
    .RESET_D1_JR_N (RESET_D1_JR_N),
    .set           (dma_start),
    .clr           (dma_done),
    .setq          (dma_setq),
    .clrq          (dma_clrq)
  );

  ejtag_setclr tif (
    .set_clock     (jtag_clock),
    .clr_clock     (CORE_CLOCK),
    .RESET_D1_JR_N (RESET_D1_JR_N),
    .set           (tif_start),
    .clr           (tif_done),
    .setq          (tif_setq),
    .clrq          (tif_clrq)
  );

  ejtag_setclr tof (
    .set_clock     (CORE_CLOCK),
    .clr_clock     (jtag_clock),
    .RESET_D1_JR_N (RESET_D1_JR_N),
    .set           (tof_start),
    .clr           (tof_done),
    .setq          (tof_setq),
    .clrq          (tof_clrq)
  );

  ejtag_setclr jtagbreak (
    .set_clock     (jtag_clock),
    .clr_clock     (CORE_CLOCK),
    .RESET_D1_JR_N (RESET_D1_JR_N),
    .set           (jtagbrk_start),
    .clr           (status.debug_entry),
    .setq          (jtagbrk_setq),
    .clrq          (jtagbrk_clrq)
  );

  ejtag_setclr pracc (
    .set_clock     (CORE_CLOCK),
    .clr_clock     (jtag_clock),
    .RESET_D1_JR_N (RESET_D1_JR_N),
    .set           (probe_access),
    .clr           (pracc_done),
    .setq          (pracc_setq),
    .clrq          (pracc_clrq)
  );

endmodule

`default_nettype wire

//--- ejtag_control/ejtag_setclr.sv
`timescale 1ns/10ps
`default_nettype none

module ejtag_setclr (
  input  wire  set_clock,
  input  wire  clr_clock,
  input  wire  RESET_D1_JR_N,
  input  wire  set,
  input  wire  clr,
  output logic setq,
  output logic clrq
);

  logic [1:0] set_rst_q;
  logic [1:0] clr_rst_q;
  logic       req_tgl;
  logic [1:0] ack_sync;
  logic       ack_tgl;
  logic [1:0] req_sync;

  always_ff @(posedge set_clock or negedge RESET_D1_JR_N) begin
    if (!RESET_D1_JR_N) begin
      set_rst_q <= 2'b00;
    end else begin
      set_rst_q <= {set_rst_q[0], 1'b1}; // Release follows the set clock.
    end
  end

  always_ff @(posedge clr_clock or negedge RESET_D1_JR_N) begin
    if (!RESET_D1_JR_N) begin
      clr_rst_q <= 2'b00;
    end else begin
      clr_rst_q <= {clr_rst_q[0], 1'b1};
    end
  end

  always_ff @(posedge set_clock or negedge set_rst_q[1]) begin
    if (!set_rst_q[1]) begin
      req_tgl  <= 1'b0;
      ack_sync <= 2'b00;
    end else begin
      ack_sync <= {ack_sync[0], ack_tgl};
      if (set && !setq) begin
        req_tgl <= ~req_tgl; // A set while busy is dropped.
      end
    end
  end

  always_ff @(posedge clr_clock or negedge clr_rst_q[1]) begin
    if (!clr_rst_q[1]) begin
      ack_tgl  <= 1'b0;
      req_sync <= 2'b00;
    end else begin
      req_sync <= {req_sync[0], req_tgl};
      if (clr && clrq) begin
        ack_tgl <= ~ack_tgl; // Only a pending request can be acknowledged.
      end
    end
  end

  assign setq = req_tgl ^ ack_sync[1];
  assign clrq = req_sync[1] ^ ack_tgl;

endmodule

`default_nettype wire

//--- common/ejtag_pkg.sv
`default_nettype none

package ejtag_pkg;

  localparam int ECR_BITS = 32;

  typedef struct packed {
    logic       wasrst;
    logic [3:0] res30_27;
    logic       res26;
    logic [1:0] pclen;
    logic       res23;
    logic       doze;
    logic       run;
    logic       perrst;
    logic       prnw;
    logic       pracc;
    logic       dmaacc;
    logic       prrst;
    logic       proben;
    logic       setdev;
    logic       res13;
    logic       jtagbrk;
    logic       dstrt;
    logic       derr;
    logic       drwn;
    logic [1:0] dsz;
    logic       res6;
    logic       dlock;
    logic       dinc;
    logic       brkst;
    logic       tif;
    logic       tof;
    logic       clken;
  } ecr_t;

  typedef struct packed {
    logic        dzs;
    logic        his;
    logic        enm;
    logic [21:0] res28_7;
    logic        tif;
    logic        tof;
    logic        mint;
    logic        mnmi;
    logic        mp;
    logic        mrst;
    logic        tm;
  } dcr_t;

  typedef struct packed {
    logic run;
    logic doze;
    logic halt;
    logic debug_entry;
  } core_status_t;

  typedef enum logic [1:0] {
    DMA_BYTE   = 2'b00,
    DMA_HALF   = 2'b01,
    DMA_WORD   = 2'b10,
    DMA_TRIPLE = 2'b11
  } dma_size_e;

  typedef struct packed {
    logic      start;
    logic      read;
    dma_size_e size;
    logic      inc;
  } dma_req_t;

  localparam ecr_t ECR_DISABLED = 32'h0006_0102; // Value forced into the ECR while disabled.

  function automatic dma_size_e dma_size_decode(input logic [1:0] dsz);
    return dma_size_e'({dsz[1], dsz[1] ^ dsz[0]}); // Core size code from the ECR dsz field.
  endfunction

endpackage

`default_nettype wire
